/* test/decode_trace.txt */
# W addr data same   (same=1 drives the write-back in the cycle of the next I record)
# I word wr_en mem_rd mem_wr vec_wr bj store_pc swr sop vop imm rs1_data rs2_data
W 01 11112222 0
W 02 a5a5f00d 0
W 03 ffffff80 0
I 34408813 1 0 0 0 0 0 04 3 00 00000000 11112222 a5a5f00d
W 02 deadbeef 1
I 34518801 1 0 0 0 0 0 05 1 00 00000000 ffffff80 deadbeef
W 06 0badcafe 1
I 34031800 1 0 0 0 0 0 00 0 00 00000000 0badcafe 0badcafe
I 247083f0 1 0 0 0 0 0 07 0 00 fffffff0 11112222 00000000
I 1481fffc 1 1 0 0 0 0 08 0 00 fffffffc ffffff80 00000000
I 19f08be0 0 0 1 0 0 0 1f 0 00 ffffffe0 11112222 deadbeef
I 1090beef 1 0 0 0 0 0 09 0 00 beef0000 11112222 00000000
I 12a01234 1 0 0 0 0 0 0a 0 00 00001234 00000000 00000000
I 0dffff00 0 0 0 0 2 0 1f 0 00 ffffff00 00000000 00000000
I 32018155 0 0 0 0 0 0 00 8 00 00000155 ffffff80 00000000
I 06208000 1 0 0 0 1 1 1f 0 00 00000000 11112222 00000000
I 0a018010 1 0 0 0 1 1 1f 0 00 00000010 ffffff80 00000000
I 04000000 0 0 0 0 1 0 00 0 00 00000000 00000000 00000000
I 3c110c00 0 0 0 1 0 0 01 0 03 00000000 deadbeef ffffff80
I 52409400 0 0 0 1 0 0 04 0 0e 00000000 11112222 00000000
I 66000000 0 0 0 1 0 0 00 0 11 00000000 00000000 00000000
I 02000000 0 0 0 0 0 0 00 0 00 00000000 00000000 00000000
I 42310400 0 0 0 0 0 0 03 0 00 00000000 deadbeef 11112222
I 00000000 0 0 0 0 0 0 00 0 00 00000000 00000000 00000000

/* sources.f */
design/isa_pkg.sv
design/control_unit.sv
design/imm_gen.sv
design/scalar_regfile.sv
design/decode_stage.sv
test/decode_props.sv
test/decode_checker.sv
test/decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module decode_tb -f sources.f \
    --Mdir "$BUILD_DIR" -o decode_sim
if [ $? -ne 0 ]; then
    echo "FAIL: compile step failed"
    exit 1
fi

"./$BUILD_DIR/decode_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "FAIL: simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "FAIL: testbench reported errors"
    exit 1
fi
echo "PASS"
exit 0

/* test/decode_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_tb;
    import isa_pkg::*;

    typedef struct packed {
        logic        is_wb;
        logic        same;     // write-back shares the next instruction's cycle
        logic [4:0]  wb_addr;
        logic [31:0] wb_data;
        logic [31:0] word;
        logic [3:0]  flags;
        logic [1:0]  bj;
        logic        spc;
        logic [4:0]  swr;
        logic [3:0]  sop;
        logic [4:0]  vop;
        logic [31:0] imm;
        logic [31:0] rs1;
        logic [31:0] rs2;
    } record_t;

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    inst_word_t  inst;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        out_valid;
    decode_out_t out;

    record_t     records[$];
    int          load_errors = 0;
    logic        loaded = 1'b0;

    decode_stage #(
        .NUM_REGS (32)
    ) dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .out_valid  (out_valid),
        .out        (out)
    );

    decode_checker chk_i (
        .clk       (clk),
        .out_valid (out_valid),
        .out       (out)
    );

    bind decode_stage decode_props props_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .out_valid  (out_valid),
        .out        (out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic load_trace();
        int          fd;
        string       line;
        byte         tag;
        int          got;
        int          want;
        logic [31:0] v [13];
        record_t     rec;
        fd = $fopen("test/decode_trace.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open test/decode_trace.txt");
            load_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            tag = (line.len() > 0) ? line.getc(0) : 8'h0a;
            rec = '0;
            got = 0;
            if (tag == "W") begin
                want = 3;
                got = $sscanf(line, "W %h %h %h", v[0], v[1], v[2]);
                rec.is_wb   = 1'b1;
                rec.wb_addr = v[0][4:0];
                rec.wb_data = v[1];
                rec.same    = v[2][0];
                if (got == want) records.push_back(rec);
            end else if (tag == "I") begin
                want = 13;
                got = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                              v[7], v[8], v[9], v[10], v[11], v[12]);
                rec.word  = v[0];
                rec.flags = {v[1][0], v[2][0], v[3][0], v[4][0]};
                rec.bj    = v[5][1:0];
                rec.spc   = v[6][0];
                rec.swr   = v[7][4:0];
                rec.sop   = v[8][3:0];
                rec.vop   = v[9][4:0];
                rec.imm   = v[10];
                rec.rs1   = v[11];
                rec.rs2   = v[12];
                if (got == want) records.push_back(rec);
            end else begin
                want = 0; // comment or blank line
            end
            if (want != 0 && got != want) begin
                $display("error: trace line not understood: %s", line);
                load_errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_inputs();
        inst_valid = 1'b0;
        wb_en      = 1'b0;
    endtask

    task automatic apply_wb(input record_t r);
        wb_en   = 1'b1;
        wb_addr = r.wb_addr;
        wb_data = r.wb_data;
    endtask

    task automatic issue(input record_t r);
        inst_valid = 1'b1;
        inst       = r.word;
        chk_i.push_expected(r.word, r.flags, r.bj, r.spc, r.swr, r.sop, r.vop,
                            r.imm, r.rs1, r.rs2);
    endtask

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = 20 * records.size() + 100;
        repeat (limit) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", limit);
        $display("Errors found");
        $finish;
    end

    initial begin : main
        record_t rec;
        record_t pend;
        logic    have_pend;
        int      total_errors;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        wb_en      = 1'b0;
        wb_addr    = '0;
        wb_data    = '0;
        have_pend  = 1'b0;
        pend       = '0;
        load_trace();
        loaded = 1'b1;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;

        foreach (records[k]) begin
            rec = records[k];
            if (rec.is_wb && rec.same) begin
                pend      = rec;
                have_pend = 1'b1;
            end else begin
                @(negedge clk);
                idle_inputs();
                if (have_pend) apply_wb(pend);
                have_pend = 1'b0;
                if (rec.is_wb) apply_wb(rec);
                else issue(rec);
            end
        end
        @(negedge clk);
        idle_inputs();

        while (chk_i.pending() != 0) @(negedge clk);
        repeat (4) @(negedge clk); // catch any stray out_valid

        total_errors = chk_i.n_errors + load_errors + dut_i.props_i.fail_count;
        $display("%0d tests, %0d passed, %0d errors", chk_i.n_tests, chk_i.n_pass,
                 total_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/decode_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_checker (
    input logic                 clk,
    input logic                 out_valid,
    input isa_pkg::decode_out_t out
);
    import isa_pkg::*;

    typedef struct packed {
        logic        halt;
        logic [3:0]  flags; // register_wr_en, mem_read, mem_write, vector_wr_en
        logic [1:0]  bj;
        logic        spc;
        logic [4:0]  swr;
        logic [3:0]  sop;
        logic [4:0]  vop;
        logic [31:0] imm;
        logic [31:0] rs1;
        logic [31:0] rs2;
    } fields_t;

    fields_t     exp_q[$];
    logic [31:0] word_q[$];
    int          n_tests = 0;
    int          n_pass = 0;
    int          n_errors = 0;

    task automatic push_expected(
        input logic [31:0] word,
        input logic [3:0]  flags,
        input logic [1:0]  bj,
        input logic        spc,
        input logic [4:0]  swr,
        input logic [3:0]  sop,
        input logic [4:0]  vop,
        input logic [31:0] imm,
        input logic [31:0] rs1,
        input logic [31:0] rs2
    );
        logic halt_exp;
        halt_exp = (word[31:25] == op_halt); // only the halt opcode raises halt
        exp_q.push_back({halt_exp, flags, bj, spc, swr, sop, vop, imm, rs1, rs2});
        word_q.push_back(word);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    function automatic fields_t observed(input decode_out_t o);
        fields_t f;
        f.halt  = o.ctrl.halt;
        f.flags = {o.ctrl.register_wr_en, o.ctrl.mem_read, o.ctrl.mem_write,
                   o.ctrl.vector_wr_en};
        f.bj  = o.ctrl.branch_jump;
        f.spc = o.ctrl.store_pc;
        f.swr = o.ctrl.scalar_write_register;
        f.sop = o.ctrl.scalar_alu_op;
        f.vop = o.ctrl.vector_alu_op;
        f.imm = o.imm;
        f.rs1 = o.rs1_data;
        f.rs2 = o.rs2_data;
        return f;
    endfunction

    function automatic string show(input fields_t f);
        return $sformatf("halt=%b en=%b bj=%b pc=%b swr=%0d sop=%h vop=%h imm=%h rs1=%h rs2=%h",
                         f.halt, f.flags, f.bj, f.spc, f.swr, f.sop, f.vop, f.imm, f.rs1,
                         f.rs2);
    endfunction

    // outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk) begin : compare
        fields_t     want;
        fields_t     got;
        logic [31:0] word;
        if (out_valid) begin
            got = observed(out);
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("error at %0t: out_valid with no instruction outstanding", $time);
            end else begin
                want = exp_q.pop_front();
                word = word_q.pop_front();
                n_tests++;
                if (got === want) begin
                    n_pass++;
                    $display("test %0d passed: word %h", n_tests, word);
                end else begin
                    n_errors++;
                    $display("mismatch at %0t: test %0d word %h expected %s got %s",
                             $time, n_tests, word, show(want), show(got));
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/decode_props.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_props (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 inst_valid,
    input logic                 out_valid,
    input isa_pkg::decode_out_t out
);

    int fail_count = 0; // read by the testbench for the final count

    a_valid_follows: assert property (@(posedge clk) disable iff (!arst_n)
        inst_valid |=> out_valid)
        else begin
            fail_count++;
            $error("out_valid missing one cycle after inst_valid");
        end

    a_no_extra_valid: assert property (@(posedge clk) disable iff (!arst_n)
        !inst_valid |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid raised without an instruction the cycle before");
        end

    a_reset_quiet: assert property (@(posedge clk) !arst_n |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high while reset is held");
        end

    a_mem_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(out.ctrl.mem_read && out.ctrl.mem_write))
        else begin
            fail_count++;
            $error("mem_read and mem_write both set");
        end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage #(
    parameter int NUM_REGS = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 inst_valid,
    input  isa_pkg::inst_word_t  inst,
    input  logic                 wb_en,
    input  logic [4:0]           wb_addr,
    input  logic [31:0]          wb_data,
    output logic                 out_valid,
    output isa_pkg::decode_out_t out
);
    import isa_pkg::*;

    localparam int AW = $clog2(NUM_REGS);

    control_bus_t ctrl;
    logic [31:0]  imm;
    logic [31:0]  rs1_data;
    logic [31:0]  rs2_data;
    decode_out_t  out_d;

    control_unit u_control_unit (
        .inst (inst),
        .ctrl (ctrl)
    );

    imm_gen u_imm_gen (
        .inst     (inst),
        .imm_type (ctrl.imm_type),
        .imm      (imm)
    );

    scalar_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_scalar_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_addr1 (ctrl.scalar_read_register1[AW-1:0]),
        .rd_addr2 (ctrl.scalar_read_register2[AW-1:0]),
        .wr_en    (wb_en),
        .wr_addr  (wb_addr[AW-1:0]),
        .wr_data  (wb_data),
        .rd_data1 (rs1_data),
        .rd_data2 (rs2_data)
    );

    assign out_d = '{ctrl: ctrl, imm: imm, rs1_data: rs1_data, rs2_data: rs2_data};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
        end else begin
            out_valid <= inst_valid; // one-cycle strobe per accepted word
            if (inst_valid) begin
                out <= out_d; // holds between instructions
            end
        end
    end

endmodule

`default_nettype wire

/* design/scalar_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module scalar_regfile #(
    parameter int  NUM_REGS = 32,
    localparam int AW       = $clog2(NUM_REGS)
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic [AW-1:0] rd_addr1,
    input  logic [AW-1:0] rd_addr2,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  logic [31:0]   wr_data,
    output logic [31:0]   rd_data1,
    output logic [31:0]   rd_data2
);

    logic [31:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle write bypasses the array
    assign rd_data1 = (wr_en && rd_addr1 == wr_addr) ? wr_data : regs[rd_addr1];
    assign rd_data2 = (wr_en && rd_addr2 == wr_addr) ? wr_data : regs[rd_addr2];

endmodule

`default_nettype wire

/* design/imm_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module imm_gen (
    input  isa_pkg::inst_word_t inst,
    input  logic [3:0]          imm_type,
    output logic [31:0]         imm
);

    always_comb begin
        case (imm_type)
            4'b0001, 4'b0011, 4'b0111: begin
                imm = {{17{inst.i.imm15[14]}}, inst.i.imm15};
            end
            4'b0010: begin
                imm = {{7{inst[24]}}, inst[24:0]}; // long branch offset over rd
            end
            4'b0100: begin
                imm = {16'h0000, inst[15:0]}; // lil
            end
            4'b1000: begin
                imm = {inst[15:0], 16'h0000}; // lih
            end
            4'b0101: begin
                // store offset is split around the rs2 field
                imm = {{17{inst.i.rd[4]}}, inst.i.rd, inst[9:0]};
            end
            4'b0110: begin
                imm = {{22{inst[9]}}, inst[9:0]};
            end
            default: begin
                imm = 32'h0000_0000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  isa_pkg::inst_word_t   inst,
    output isa_pkg::control_bus_t ctrl
);
    import isa_pkg::*;

    opcode_e op;

    assign op = inst.r.opcode;

    always_comb begin
        ctrl = '0;
        ctrl.vector_read_register1 = inst.r.rs2;
        ctrl.vector_read_register2 = inst.r.rs1;
        ctrl.scalar_read_register1 = inst.r.rs1;
        ctrl.scalar_read_register2 = inst.r.rs2;
        ctrl.vector_write_register = inst.r.rd;
        ctrl.scalar_write_register = inst.r.rd;

        case (op)
            op_halt: ctrl.halt = 1'b1;
            op_jmp, op_jal, op_jmpr, op_jalr: begin
                ctrl.branch_jump = 2'b01;
                if (op == op_jal || op == op_jalr) begin
                    ctrl.register_wr_en = 1'b1;
                    ctrl.scalar_write_register = LINK_REG;
                    ctrl.store_pc = 1'b1;
                end
                if (op == op_jmpr || op == op_jalr) begin
                    ctrl.branch_register = 1'b1;
                    ctrl.imm_type = 4'b0001;
                    ctrl.r_read1 = 1'b1;
                end
            end
            op_bi: begin
                ctrl.branch_jump = 2'b10;
                ctrl.imm_type = 4'b0010;
            end
            op_br: begin
                ctrl.branch_jump = 2'b10;
                ctrl.branch_register = 1'b1;
                ctrl.imm_type = 4'b0011;
                ctrl.r_read1 = 1'b1;
            end
            op_lih, op_lil: begin
                ctrl.register_wr_en = 1'b1;
                ctrl.imm_type = (op == op_lih) ? 4'b1000 : 4'b0100;
            end
            op_ld32, op_ld36: begin
                ctrl.register_wr_en = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.r_type = (op == op_ld32) ? 2'b01 : 2'b10;
                ctrl.alu_operands = 1'b1;
                ctrl.imm_type = 4'b0011;
                ctrl.r_read1 = 1'b1;
            end
            op_st32, op_st36: begin
                ctrl.mem_write = 1'b1;
                ctrl.w_type = (op == op_st32) ? 2'b01 : 2'b10;
                ctrl.alu_operands = 1'b1;
                ctrl.imm_type = 4'b0101;
                ctrl.r_read1 = 1'b1;
                ctrl.r_read2 = 1'b1;
            end
            op_vldi, op_vldr, op_vsti, op_vstr: begin
                ctrl.vector_wr_en = 1'b1;
                ctrl.register_wr_en = 1'b1;
                ctrl.scalar_write_register = inst.r.rs1; // base register write-back
                ctrl.r_read1 = 1'b1;
                ctrl.r_read2 = (op != op_vsti);
                if (op == op_vldi || op == op_vsti) begin
                    ctrl.alu_operands = 1'b1;
                    ctrl.imm_type = 4'b0110;
                end
                if (op == op_vldi || op == op_vldr) begin
                    ctrl.mem_read = 1'b1;
                    ctrl.r_type = 2'b11;
                end else begin
                    ctrl.mem_write = 1'b1;
                    ctrl.w_type = 2'b11;
                    ctrl.v_read1 = 1'b1;
                end
            end
            op_addi, op_subi, op_andi, op_ori, op_xori, op_shli, op_shri: begin
                ctrl.register_wr_en = 1'b1;
                ctrl.alu_operands = 1'b1;
                ctrl.imm_type = 4'b0110;
                ctrl.r_read1 = 1'b1;
            end
            op_cmpi: begin
                ctrl.alu_operands = 1'b1;
                ctrl.imm_type = 4'b0111;
                ctrl.r_read1 = 1'b1;
            end
            op_alu, op_falu: begin
                ctrl.register_wr_en = 1'b1;
                ctrl.r_read1 = 1'b1;
                ctrl.r_read2 = 1'b1;
            end
            op_not: begin
                ctrl.register_wr_en = 1'b1;
                ctrl.r_read1 = 1'b1;
            end
            op_cmp, op_cmpdec, op_cmpinc: begin
                ctrl.r_read1 = 1'b1;
                ctrl.r_read2 = 1'b1;
            end
            op_vadd, op_vsub, op_vmult, op_vmax, op_vmin: begin
                ctrl.vector_wr_en = 1'b1;
                ctrl.v_read1 = 1'b1;
                ctrl.v_read2 = 1'b1;
            end
            op_vdot, op_vdota: begin
                ctrl.register_wr_en = 1'b1;
                ctrl.v_read1 = 1'b1;
                ctrl.v_read2 = 1'b1;
                if (op == op_vdota) begin
                    ctrl.vector_read_register2 = inst.r.rs3;
                    ctrl.r_read1 = 1'b1;
                end
            end
            op_vindx, op_vreduce: begin
                ctrl.register_wr_en = 1'b1;
                ctrl.v_read1 = 1'b1;
            end
            op_vsplat, op_vswizzle: begin
                ctrl.vector_wr_en = 1'b1;
                ctrl.v_read1 = 1'b1;
            end
            op_vsadd, op_vsmult, op_vssub: begin
                ctrl.vector_wr_en = 1'b1;
                ctrl.v_read2 = 1'b1;
                ctrl.r_read1 = 1'b1; // scalar operand
            end
            op_vsma: begin
                ctrl.vector_wr_en = 1'b1;
                ctrl.vector_read_register2 = inst.r.rs3;
                ctrl.v_read1 = 1'b1;
                ctrl.v_read2 = 1'b1;
                ctrl.r_read1 = 1'b1;
            end
            op_writea, op_writeb, op_writec: begin
                ctrl.matmul_opcode = (op == op_writea) ? 3'b000 :
                                     (op == op_writeb) ? 3'b001 : 3'b010;
                ctrl.v_read1 = 1'b1;
                ctrl.v_read2 = 1'b1;
            end
            op_matmul: ctrl.matmul_opcode = 3'b011;
            op_readc: begin
                ctrl.vector_wr_en = 1'b1;
                ctrl.matmul_opcode = 3'b100;
                ctrl.matmul_high_low = inst.r.rs1[1]; // word bit 16
            end
            op_vcomp: begin
                ctrl.vector_wr_en = 1'b1;
                ctrl.v_read1 = 1'b1;
                ctrl.v_read2 = 1'b1;
                ctrl.r_read1 = 1'b1;
                ctrl.r_read2 = 1'b1;
            end
            op_fa, op_cmpx: begin
                ctrl.register_wr_en = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.r_type = 2'b10;
                ctrl.r_read1 = 1'b1;
                ctrl.r_read2 = (op == op_cmpx);
            end
            op_flushdirty, op_flushclean, op_flushline: begin
                ctrl.data_cache_flush = 1'b1;
                ctrl.dirty = (op == op_flushdirty);
                ctrl.clean = (op == op_flushclean);
            end
            op_flushicache: ctrl.flushicache = 1'b1;
            default: ; // nop and the unimplemented ops keep the defaults
        endcase

        // alu selections, kept apart from the enables above
        case (op)
            op_subi: ctrl.scalar_alu_op = sop_sub;
            op_andi: ctrl.scalar_alu_op = sop_and;
            op_ori: ctrl.scalar_alu_op = sop_or;
            op_xori: ctrl.scalar_alu_op = sop_xor;
            op_shli: ctrl.scalar_alu_op = sop_shl;
            op_shri: ctrl.scalar_alu_op = sop_shr;
            op_cmpi, op_cmp, op_cmpdec, op_cmpinc: ctrl.scalar_alu_op = sop_cmp;
            op_alu: ctrl.scalar_alu_op = inst.r.func[3:0];
            op_falu: ctrl.vector_alu_op = {2'b00, inst.r.func[2:0]}; // ff ops only
            op_vadd: ctrl.vector_alu_op = vop_vvadd;
            op_vsub: ctrl.vector_alu_op = vop_vvsub;
            op_vmult: ctrl.vector_alu_op = vop_vvmult;
            op_vdot: ctrl.vector_alu_op = vop_vvdot;
            op_vdota: ctrl.vector_alu_op = vop_vvdota;
            op_vindx: ctrl.vector_alu_op = vop_vvindx;
            op_vreduce: ctrl.vector_alu_op = vop_vvreduce;
            op_vsplat: ctrl.vector_alu_op = vop_vvsplat;
            op_vswizzle: ctrl.vector_alu_op = vop_vvswizzle;
            op_vsadd: ctrl.vector_alu_op = vop_vvsadd;
            op_vsmult: ctrl.vector_alu_op = vop_vvsmult;
            op_vssub: ctrl.vector_alu_op = vop_vvssub;
            op_vsma: ctrl.vector_alu_op = vop_vvsma;
            op_vmax: ctrl.vector_alu_op = vop_vvmax;
            op_vmin: ctrl.vector_alu_op = vop_vvmin;
            op_vcomp: ctrl.vector_alu_op = vop_vvcompsel;
            default: ctrl.scalar_alu_op = sop_add; // loads, stores and addi use add
        endcase
    end

endmodule

`default_nettype wire

/* design/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef enum logic [6:0] {
        op_halt, op_nop, op_jmp, op_jal, op_jmpr, op_jalr, op_bi, op_br,
        op_lih, op_lil, op_ld32, op_ld36, op_st32, op_st36,
        op_vldi, op_vsti, op_vldr, op_vstr,
        op_addi, op_subi, op_andi, op_ori, op_xori, op_shli, op_shri, op_cmpi,
        op_alu, op_not, op_falu, op_cmp,
        op_vadd, op_vsub, op_vmult, op_vdiv, op_vdot, op_vdota, op_vindx, op_vreduce,
        op_vsplat, op_vswizzle, op_vsadd, op_vsmult, op_vssub, op_vsdiv, op_vsma,
        op_writea, op_writeb, op_writec, op_matmul, op_readc, op_systolicstep,
        op_vmax, op_vmin, op_vcomp, op_ftoi, op_itof, op_wcsr, op_rcsr,
        op_fa, op_cmpx, op_flushdirty, op_flushclean, op_flushicache, op_flushline,
        op_cmpdec, op_cmpinc
    } opcode_e;

    typedef enum logic [4:0] {
        vop_ffadd, vop_ffsub, vop_ffmult,
        vop_vvadd, vop_vvsub, vop_vvmult, vop_vvdot, vop_vvdota,
        vop_vvindx, vop_vvreduce, vop_vvsplat, vop_vvswizzle,
        vop_vvsadd, vop_vvssub, vop_vvsmult, vop_vvsma,
        vop_vvcompsel, vop_vvmax, vop_vvmin
    } vec_op_e;

    typedef enum logic [3:0] {
        sop_add = 4'd0,
        sop_sub = 4'd1,
        sop_and = 4'd2,
        sop_or  = 4'd3,
        sop_xor = 4'd4,
        sop_shl = 4'd5,
        sop_shr = 4'd7,
        sop_cmp = 4'd8
    } scalar_op_e;

    localparam logic [4:0] LINK_REG = 5'd31;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rs3;
        logic [4:0] func;
    } inst_r_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [14:0] imm15;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_word_t;

    typedef struct packed {
        logic       halt;
        logic       flushicache;
        logic       data_cache_flush;
        logic       dirty;
        logic       clean;
        logic       matrix_mutplier_en;
        logic       vector_wr_en;
        logic       register_wr_en;
        logic       mem_read;
        logic       mem_write;
        logic       matmul_high_low;
        logic       branch_register;
        logic       store_pc;
        logic       alu_operands; // 1 selects the immediate as operand b
        logic       r_read1;
        logic       r_read2;
        logic       v_read1;
        logic       v_read2;
        logic [4:0] vector_read_register1;
        logic [4:0] vector_read_register2;
        logic [4:0] scalar_read_register1;
        logic [4:0] scalar_read_register2;
        logic [4:0] vector_write_register;
        logic [4:0] scalar_write_register;
        logic [4:0] vector_alu_op;
        logic [3:0] scalar_alu_op;
        logic [3:0] imm_type;
        logic [1:0] w_type;
        logic [1:0] r_type;
        logic [1:0] branch_jump; // 01 jump, 10 branch
        logic [2:0] matmul_opcode;
    } control_bus_t;

    typedef struct packed {
        control_bus_t ctrl;
        logic [31:0]  imm;
        logic [31:0]  rs1_data;
        logic [31:0]  rs2_data;
    } decode_out_t;

endpackage

`default_nettype wire
